/* Makefile */
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_psx_loader -Mdir $(BUILD_DIR) -f files.f
	@out="$$(./$(BUILD_DIR)/Vtb_psx_loader)"; echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* design/download_decoder.sv */
//==================================================
// Download decoder
// Kind flags from the download index, core reset
//==================================================

`timescale 1ns/100ps

module download_decoder (
	input  logic                                   clk_1x,
	input  logic                                   rst,
	input  logic                                   ioctl_download,
	input  logic [psx_loader_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
	input  logic                                   reset_request,
	output logic                                   bios_dl,
	output logic                                   exe_dl,
	output logic                                   cd_dl,
	output logic                                   sbi_dl,
	output logic                                   cdinfo_dl,
	output logic                                   core_reset
);

	import psx_loader_pkg::*;

	// One flag per download kind, registered
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			bios_dl   <= 1'b0;
			exe_dl    <= 1'b0;
			cd_dl     <= 1'b0;
			sbi_dl    <= 1'b0;
			cdinfo_dl <= 1'b0;
		end else begin
			bios_dl   <= ioctl_download & (ioctl_index == IDX_BIOS);
			exe_dl    <= ioctl_download & (ioctl_index == IDX_EXE);
			// Masked compare for the CD entries
			cd_dl     <= ioctl_download &
				(ioctl_index[CD_INDEX_BITS-1:0] == IDX_CD[CD_INDEX_BITS-1:0]);
			sbi_dl    <= ioctl_download & (ioctl_index == IDX_SBI);
			cdinfo_dl <= ioctl_download & (ioctl_index == IDX_CDINFO);
		end
	end

	// Core held in reset while an image streams into RAM
	assign core_reset = rst | reset_request | bios_dl | exe_dl | cd_dl;

endmodule

/* design/media_tracker.sv */
//==================================================
// Media tracker
// Exe load pulse, CD presence, protection key
//==================================================

`timescale 1ns/100ps

module media_tracker (
	input  logic                                  clk_1x,
	input  logic                                  rst,
	input  logic                                  exe_dl,
	input  logic                                  cd_dl,
	input  logic                                  sbi_dl,
	input  logic                                  ioctl_wr,
	input  logic                                  cd_mount,
	input  logic [psx_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [psx_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic [psx_loader_pkg::IMG_SIZE_W-1:0]   img_size,
	output logic                                  exe_load,
	output logic                                  has_cd,
	output logic                                  new_cd,
	output logic                                  cd_hps_on,
	output logic [psx_loader_pkg::CD_SIZE_W-1:0]    cd_size,
	output logic [psx_loader_pkg::IOCTL_DATA_W-1:0] libcrypt_key
);

	import psx_loader_pkg::*;

	logic exe_dl_q;
	logic cd_dl_q;
	logic cd_dl_done;
	logic mount_full;
	logic mount_empty;

	// End of download by falling edge of the kind flag
	assign cd_dl_done  = cd_dl_q & ~cd_dl;
	assign mount_full  = cd_mount & (img_size != '0);
	assign mount_empty = cd_mount & (img_size == '0);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			exe_dl_q  <= 1'b0;
			cd_dl_q   <= 1'b0;
			exe_load  <= 1'b0;
			has_cd    <= 1'b0;
			new_cd    <= 1'b0;
			cd_hps_on <= 1'b0;
		end else begin
			exe_dl_q <= exe_dl;
			cd_dl_q  <= cd_dl;
			exe_load <= exe_dl_q & ~exe_dl;
			new_cd   <= mount_full;

			// Downloaded CD, served from RAM
			if (cd_dl_done) begin
				has_cd    <= 1'b1;
				cd_hps_on <= 1'b0;
			end

			// SD mount takes over, read via the host
			if (mount_full) begin
				has_cd    <= 1'b1;
				cd_hps_on <= 1'b1;
			end else if (mount_empty) begin
				has_cd <= 1'b0;
			end
		end
	end

	//==================================================
	// Image size and key
	//==================================================

	// Last download address is the image length
	always_ff @(posedge clk_1x) begin
		if (mount_full) begin
			cd_size <= img_size[CD_SIZE_W-1:0];
		end else if (cd_dl_done) begin
			cd_size <= {{(CD_SIZE_W-IOCTL_ADDR_W){1'b0}}, ioctl_addr};
		end
		if (sbi_dl && ioctl_wr) begin
			libcrypt_key <= ioctl_dout;
		end
	end

endmodule

/* design/memcard_control.sv */
//==================================================
// Memory card control
// Mount flags, load and save pulses
//==================================================

`timescale 1ns/100ps

module memcard_control (
	input  logic                                clk_1x,
	input  logic                                rst,
	input  logic                                card1_mount,
	input  logic                                card2_mount,
	input  logic                                card_load_menu,
	input  logic                                card_save_menu,
	input  logic                                osd_status,
	input  logic                                autosave_en,
	input  logic [psx_loader_pkg::IMG_SIZE_W-1:0] img_size,
	output logic                                card1_available,
	output logic                                card2_available,
	output logic                                card1_load,
	output logic                                card2_load,
	output logic                                card_save
);

	logic size_nz;
	logic autosave;
	logic load_menu_q;
	logic save_menu_q;
	logic autosave_q;
	logic load_edge;
	logic save_edge;

	assign size_nz  = (img_size != '0);
	// Autosave fires when the OSD opens
	assign autosave = osd_status & autosave_en;

	assign load_edge = card_load_menu & ~load_menu_q;
	assign save_edge = (card_save_menu & ~save_menu_q) | (autosave & ~autosave_q);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			load_menu_q     <= 1'b0;
			save_menu_q     <= 1'b0;
			autosave_q      <= 1'b0;
			card1_available <= 1'b0;
			card2_available <= 1'b0;
			card1_load      <= 1'b0;
			card2_load      <= 1'b0;
			card_save       <= 1'b0;
		end else begin
			load_menu_q <= card_load_menu;
			save_menu_q <= card_save_menu;
			autosave_q  <= autosave;

			// Empty mount ejects the card
			if (card1_mount) begin
				card1_available <= size_nz;
			end
			if (card2_mount) begin
				card2_available <= size_nz;
			end

			card1_load <= (card1_mount & size_nz) | load_edge;
			card2_load <= (card2_mount & size_nz) | load_edge;
			card_save  <= save_edge;
		end
	end

endmodule

/* design/psx_loader_pkg.sv */
//==================================================
// Loader package
// Download widths, indices, region offsets, slots
//==================================================

package psx_loader_pkg;

	//==================================================
	// Host download stream
	//==================================================

	// Byte address of the current half-word
	localparam int unsigned IOCTL_ADDR_W  = 27;
	// One download half-word
	localparam int unsigned IOCTL_DATA_W  = 16;
	// File index chosen in the menu
	localparam int unsigned IOCTL_INDEX_W = 8;

	// Packed RAM word, two halves
	localparam int unsigned RAM_DATA_W = 32;

	//==================================================
	// Download indices
	//==================================================

	localparam logic [IOCTL_INDEX_W-1:0] IDX_BIOS   = 8'd0;
	localparam logic [IOCTL_INDEX_W-1:0] IDX_EXE    = 8'd1;
	localparam logic [IOCTL_INDEX_W-1:0] IDX_CD     = 8'd2;
	localparam logic [IOCTL_INDEX_W-1:0] IDX_SBI    = 8'd250;
	localparam logic [IOCTL_INDEX_W-1:0] IDX_CDINFO = 8'd251;

	// CD index is matched on its low bits only,
	// upper bits carry the menu entry variant
	localparam int unsigned CD_INDEX_BITS = 6;

	//==================================================
	// RAM regions
	//==================================================

	// BIOS lives at 2 MB
	localparam logic [IOCTL_ADDR_W-1:0] BIOS_START = 27'd2097152;
	// Executable image at 4 MB
	localparam logic [IOCTL_ADDR_W-1:0] EXE_START  = 27'd4194304;

	//==================================================
	// Mounted images
	//==================================================

	localparam int unsigned CD_SIZE_W  = 30;
	localparam int unsigned IMG_SIZE_W = 64;

	// Image slot numbers, one mount strobe each
	localparam int unsigned SLOT_CD    = 1;
	localparam int unsigned SLOT_CARD1 = 2;
	localparam int unsigned SLOT_CARD2 = 3;

	localparam int unsigned MOUNT_W = 4;

endpackage

/* design/psx_loader_top.sv */
//==================================================
// Loader top
// Download decode, RAM loader, media and card glue
//==================================================

`timescale 1ns/100ps

module psx_loader_top (
	input  logic                                   clk_1x,
	input  logic                                   rst,
	input  logic                                   ioctl_download,
	input  logic [psx_loader_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
	input  logic [psx_loader_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  logic [psx_loader_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	input  logic                                   ioctl_wr,
	input  logic                                   ram_ack,
	input  logic [psx_loader_pkg::MOUNT_W-1:0]       img_mounted,
	input  logic [psx_loader_pkg::IMG_SIZE_W-1:0]    img_size,
	input  logic                                   reset_request,
	input  logic                                   card_load_menu,
	input  logic                                   card_save_menu,
	input  logic                                   osd_status,
	input  logic                                   autosave_en,
	output logic                                   core_reset,
	output logic [psx_loader_pkg::IOCTL_ADDR_W-1:0]  ram_addr,
	output logic [psx_loader_pkg::RAM_DATA_W-1:0]    ram_data,
	output logic                                   ram_wr,
	output logic                                   trackinfo_wr,
	output logic                                   ioctl_wait,
	output logic                                   exe_load,
	output logic                                   has_cd,
	output logic                                   new_cd,
	output logic                                   cd_hps_on,
	output logic [psx_loader_pkg::CD_SIZE_W-1:0]     cd_size,
	output logic [psx_loader_pkg::IOCTL_DATA_W-1:0]  libcrypt_key,
	output logic                                   card1_available,
	output logic                                   card2_available,
	output logic                                   card1_load,
	output logic                                   card2_load,
	output logic                                   card_save
);

	import psx_loader_pkg::*;

	// Download kind flags
	logic bios_dl;
	logic exe_dl;
	logic cd_dl;
	logic sbi_dl;
	logic cdinfo_dl;

	download_decoder u_decoder (
		.clk_1x         (clk_1x),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.reset_request  (reset_request),
		.bios_dl        (bios_dl),
		.exe_dl         (exe_dl),
		.cd_dl          (cd_dl),
		.sbi_dl         (sbi_dl),
		.cdinfo_dl      (cdinfo_dl),
		.core_reset     (core_reset)
	);

	ram_download u_ram_download (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.bios_dl      (bios_dl),
		.exe_dl       (exe_dl),
		.cd_dl        (cd_dl),
		.cdinfo_dl    (cdinfo_dl),
		.ioctl_wr     (ioctl_wr),
		.ram_ack      (ram_ack),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ram_addr     (ram_addr),
		.ram_data     (ram_data),
		.ram_wr       (ram_wr),
		.trackinfo_wr (trackinfo_wr),
		.ioctl_wait   (ioctl_wait)
	);

	// Mount strobes split per slot
	media_tracker u_media (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.exe_dl       (exe_dl),
		.cd_dl        (cd_dl),
		.sbi_dl       (sbi_dl),
		.ioctl_wr     (ioctl_wr),
		.cd_mount     (img_mounted[SLOT_CD]),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.img_size     (img_size),
		.exe_load     (exe_load),
		.has_cd       (has_cd),
		.new_cd       (new_cd),
		.cd_hps_on    (cd_hps_on),
		.cd_size      (cd_size),
		.libcrypt_key (libcrypt_key)
	);

	memcard_control u_memcard (
		.clk_1x          (clk_1x),
		.rst             (rst),
		.card1_mount     (img_mounted[SLOT_CARD1]),
		.card2_mount     (img_mounted[SLOT_CARD2]),
		.card_load_menu  (card_load_menu),
		.card_save_menu  (card_save_menu),
		.osd_status      (osd_status),
		.autosave_en     (autosave_en),
		.img_size        (img_size),
		.card1_available (card1_available),
		.card2_available (card2_available),
		.card1_load      (card1_load),
		.card2_load      (card2_load),
		.card_save       (card_save)
	);

endmodule

/* design/ram_download.sv */
//==================================================
// RAM download
// Packs half-word pairs into 32-bit RAM writes
//==================================================

`timescale 1ns/100ps

module ram_download (
	input  logic                                  clk_1x,
	input  logic                                  rst,
	input  logic                                  bios_dl,
	input  logic                                  exe_dl,
	input  logic                                  cd_dl,
	input  logic                                  cdinfo_dl,
	input  logic                                  ioctl_wr,
	input  logic                                  ram_ack,
	input  logic [psx_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [psx_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	output logic [psx_loader_pkg::IOCTL_ADDR_W-1:0] ram_addr,
	output logic [psx_loader_pkg::RAM_DATA_W-1:0]   ram_data,
	output logic                                  ram_wr,
	output logic                                  trackinfo_wr,
	output logic                                  ioctl_wait
);

	import psx_loader_pkg::*;

	logic ram_bound;
	logic low_half;
	logic high_half;

	// Any download that ends up in RAM
	assign ram_bound = bios_dl | exe_dl | cd_dl | cdinfo_dl;

	assign low_half  = ram_bound & ioctl_wr & ~ioctl_addr[1];
	assign high_half = ram_bound & ioctl_wr & ioctl_addr[1];

	//==================================================
	// Word assembly
	//==================================================

	// Address is taken with the low half,
	// relocated into the BIOS or executable region
	always_ff @(posedge clk_1x) begin
		if (low_half) begin
			ram_data[IOCTL_DATA_W-1:0] <= ioctl_dout;
			if (bios_dl) begin
				ram_addr <= ioctl_addr + BIOS_START;
			end else if (exe_dl) begin
				ram_addr <= ioctl_addr + EXE_START;
			end else begin
				ram_addr <= ioctl_addr;
			end
		end
		if (high_half) begin
			ram_data[RAM_DATA_W-1:IOCTL_DATA_W] <= ioctl_dout;
		end
	end

	//==================================================
	// Write strobe and host hold
	//==================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			ram_wr       <= 1'b0;
			trackinfo_wr <= 1'b0;
			ioctl_wait   <= 1'b0;
		end else begin
			ram_wr       <= high_half;
			trackinfo_wr <= high_half & cdinfo_dl;
			if (!ram_bound) begin
				ioctl_wait <= 1'b0;
			end else begin
				if (ram_ack) begin
					ioctl_wait <= 1'b0;
				end
				// Track info goes to internal storage, no hold
				if (high_half) begin
					ioctl_wait <= ~cdinfo_dl;
				end
			end
		end
	end

endmodule

/* files.f */
design/psx_loader_pkg.sv
design/download_decoder.sv
design/ram_download.sv
design/media_tracker.sv
design/memcard_control.sv
design/psx_loader_top.sv
testbench/tb_psx_loader.sv

/* testbench/tb_psx_loader.sv */
//==================================================
// Loader testbench
// Downloads, CD and card events, RAM ack model
//==================================================

`timescale 1ns/100ps

module tb_psx_loader;

	import psx_loader_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int BIOS_WORDS = 24;
	localparam int EXE_WORDS  = 16;
	localparam int CD_WORDS   = 12;
	localparam int INFO_WORDS = 8;
	// Up to 10 cycles per word, plus the event tests
	localparam int WATCHDOG_NS =
		((BIOS_WORDS + EXE_WORDS + CD_WORDS + INFO_WORDS) * 10 + 300) * CLK_PERIOD;

	logic clk_1x;
	logic rst;
	logic ioctl_download, ioctl_wr, ram_ack, reset_request;
	logic card_load_menu, card_save_menu, osd_status, autosave_en;
	logic [IOCTL_INDEX_W-1:0] ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr, ram_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout, libcrypt_key;
	logic [MOUNT_W-1:0] img_mounted;
	logic [IMG_SIZE_W-1:0] img_size;
	logic [RAM_DATA_W-1:0] ram_data;
	logic [CD_SIZE_W-1:0] cd_size;
	logic core_reset, ram_wr, trackinfo_wr, ioctl_wait;
	logic exe_load, has_cd, new_cd, cd_hps_on;
	logic card1_available, card2_available, card1_load, card2_load, card_save;

	integer data_seed = 6;
	integer ack_seed = 6;
	int errors = 0;
	int checks = 0;
	int exe_loads = 0;
	int new_cds = 0;
	int card_saves = 0;
	logic [IOCTL_DATA_W-1:0] key;
	logic [IOCTL_ADDR_W-1:0] last_addr;

	// Expected RAM writes, in order
	logic [IOCTL_ADDR_W-1:0] exp_addr[$];
	logic [RAM_DATA_W-1:0] exp_data[$];
	logic exp_ti[$];

	psx_loader_top dut0 (.*);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	task automatic next_cycle();
		@(posedge clk_1x);
		#10;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			next_cycle();
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// Half-word pairs, host held off while ioctl_wait is high
	task automatic send_download(input logic [IOCTL_INDEX_W-1:0] index,
			input logic [IOCTL_ADDR_W-1:0] offset, input int words, input logic holds_core);
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [31:0] word;
		int waited;
		addr = '0;
		ioctl_index = index;
		ioctl_download = 1'b1;
		check_value("core_reset", 64'(1'b0), 64'(core_reset));
		next_cycle();
		check_value("core_reset", 64'(holds_core), 64'(core_reset));
		for (int i = 0; i < words; i++) begin
			word = $random(data_seed);
			ioctl_addr = addr;
			ioctl_dout = word[15:0];
			ioctl_wr = 1'b1;
			next_cycle();
			ioctl_addr = addr + 27'd2;
			ioctl_dout = word[31:16];
			exp_addr.push_back(addr + offset);
			exp_data.push_back(word);
			exp_ti.push_back(index == IDX_CDINFO);
			next_cycle();
			ioctl_wr = 1'b0;
			waited = 0;
			while (ioctl_wait && waited < 8) begin
				next_cycle();
				waited++;
			end
			if (ioctl_wait) begin
				report_error("host still held by ioctl_wait, memory never acknowledged");
			end
			addr = addr + 27'd4;
		end
		last_addr = ioctl_addr;
		ioctl_download = 1'b0;
		check_value("core_reset", 64'(holds_core), 64'(core_reset));
		next_cycle();
		check_value("core_reset", 64'(1'b0), 64'(core_reset));
		check_value("pending RAM writes", 64'(0), 64'(exp_addr.size()));
	endtask

	task automatic mount(input int slot, input logic [IMG_SIZE_W-1:0] size);
		img_mounted = '0;
		img_mounted[slot] = 1'b1;
		img_size = size;
		next_cycle();
		img_mounted = '0;
	endtask

	//==================================================
	// Memory model and write scoreboard
	//==================================================

	initial begin
		int delay;
		ram_ack = 1'b0;
		forever begin
			next_cycle();
			if (ram_wr && ioctl_wait) begin
				delay = 1 + int'({$random(ack_seed)} % 32'd4);
				idle_cycles(delay - 1);
				ram_ack = 1'b1;
				next_cycle();
				ram_ack = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk_1x);
			#5;
			if (ram_wr === 1'b1) begin
				if (exp_addr.size() == 0) begin
					report_error("RAM write issued with no half-word pair sent");
				end else begin
					check_value("ram_addr", 64'(exp_addr.pop_front()), 64'(ram_addr));
					check_value("ram_data", 64'(exp_data.pop_front()), 64'(ram_data));
					check_value("trackinfo_wr", 64'(exp_ti.pop_front()), 64'(trackinfo_wr));
				end
			end
		end
	end

	// Pulse counts over the whole run
	initial begin
		forever begin
			@(posedge clk_1x);
			#5;
			if (exe_load === 1'b1) begin
				exe_loads++;
			end
			if (new_cd === 1'b1) begin
				new_cds++;
			end
			if (card_save === 1'b1) begin
				card_saves++;
			end
		end
	end

	assert property (@(posedge clk_1x) disable iff (rst) ram_wr |=> !ram_wr)
		else report_error("ram_wr lasted more than one cycle");
	assert property (@(posedge clk_1x) disable iff (rst) (ram_wr && !trackinfo_wr) |-> ioctl_wait)
		else report_error("ioctl_wait did not rise with ram_wr");
	assert property (@(posedge clk_1x) disable iff (rst)
		$rose(ioctl_wait) |-> (ram_wr && !trackinfo_wr))
		else report_error("ioctl_wait rose without a RAM write");
	assert property (@(posedge clk_1x) disable iff (rst) (ioctl_wait && ram_ack) |=> !ioctl_wait)
		else report_error("ioctl_wait did not fall the cycle after ram_ack");
	assert property (@(posedge clk_1x) disable iff (rst) (ioctl_wait && !ram_ack) |=> ioctl_wait)
		else report_error("ioctl_wait fell before ram_ack");
	assert property (@(posedge clk_1x) disable iff (rst) trackinfo_wr |-> (ram_wr && !ioctl_wait))
		else report_error("track-info write without ram_wr or with the host held");
	assert property (@(posedge clk_1x) disable iff (rst) exe_load |=> !exe_load)
		else report_error("exe_load lasted more than one cycle");
	assert property (@(posedge clk_1x) disable iff (rst) new_cd |=> !new_cd)
		else report_error("new_cd lasted more than one cycle");
	assert property (@(posedge clk_1x) disable iff (rst) card_save |=> !card_save)
		else report_error("card_save lasted more than one cycle");

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	//==================================================
	// Test sequence
	//==================================================

	initial begin
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		img_mounted = '0;
		img_size = '0;
		reset_request = 1'b0;
		card_load_menu = 1'b0;
		card_save_menu = 1'b0;
		osd_status = 1'b0;
		autosave_en = 1'b0;
		repeat (3) begin
			next_cycle();
			check_value("core_reset", 64'(1'b1), 64'(core_reset));
		end
		rst = 1'b0;
		next_cycle();
		check_value("core_reset", 64'(1'b0), 64'(core_reset));
		check_value("ioctl_wait", 64'(1'b0), 64'(ioctl_wait));
		check_value("has_cd", 64'(1'b0), 64'(has_cd));
		check_value("card1_available", 64'(1'b0), 64'(card1_available));

		// Menu reset goes straight through
		reset_request = 1'b1;
		#1;
		check_value("core_reset", 64'(1'b1), 64'(core_reset));
		next_cycle();
		reset_request = 1'b0;
		#1;
		check_value("core_reset", 64'(1'b0), 64'(core_reset));
		next_cycle();

		send_download(IDX_BIOS, BIOS_START, BIOS_WORDS, 1'b1);
		idle_cycles(2);

		// exe_load two cycles after the download drops
		send_download(IDX_EXE, EXE_START, EXE_WORDS, 1'b1);
		check_value("exe_load", 64'(1'b0), 64'(exe_load));
		next_cycle();
		check_value("exe_load", 64'(1'b1), 64'(exe_load));
		next_cycle();
		check_value("exe_load", 64'(1'b0), 64'(exe_load));

		send_download(IDX_CDINFO, '0, INFO_WORDS, 1'b0);
		idle_cycles(2);

		// Upper index bits select a CD menu variant
		send_download(8'h42, '0, CD_WORDS, 1'b1);
		next_cycle();
		check_value("cd_size", 64'(last_addr), 64'(cd_size));
		check_value("has_cd", 64'(1'b1), 64'(has_cd));
		check_value("cd_hps_on", 64'(1'b0), 64'(cd_hps_on));

		mount(SLOT_CD, 64'h1234_5678);
		check_value("cd_size", 64'h1234_5678, 64'(cd_size));
		check_value("has_cd", 64'(1'b1), 64'(has_cd));
		check_value("cd_hps_on", 64'(1'b1), 64'(cd_hps_on));
		check_value("new_cd", 64'(1'b1), 64'(new_cd));
		next_cycle();
		check_value("new_cd", 64'(1'b0), 64'(new_cd));
		mount(SLOT_CD, '0);
		check_value("has_cd", 64'(1'b0), 64'(has_cd));
		check_value("new_cd", 64'(1'b0), 64'(new_cd));

		// Protection key, no RAM traffic and no core reset
		ioctl_index = IDX_SBI;
		ioctl_download = 1'b1;
		next_cycle();
		key = 16'hc35a ^ 16'(data_seed);
		ioctl_addr = '0;
		ioctl_dout = key;
		ioctl_wr = 1'b1;
		check_value("core_reset", 64'(1'b0), 64'(core_reset));
		next_cycle();
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		check_value("libcrypt_key", 64'(key), 64'(libcrypt_key));
		idle_cycles(2);

		//==================================================
		// Memory cards
		//==================================================

		mount(SLOT_CARD1, 64'd131072);
		check_value("card1_available", 64'(1'b1), 64'(card1_available));
		check_value("card1_load", 64'(1'b1), 64'(card1_load));
		check_value("card2_load", 64'(1'b0), 64'(card2_load));
		next_cycle();
		check_value("card1_load", 64'(1'b0), 64'(card1_load));
		mount(SLOT_CARD2, 64'd131072);
		check_value("card2_available", 64'(1'b1), 64'(card2_available));
		check_value("card2_load", 64'(1'b1), 64'(card2_load));
		check_value("card1_load", 64'(1'b0), 64'(card1_load));
		mount(SLOT_CARD1, '0);
		check_value("card1_available", 64'(1'b0), 64'(card1_available));
		check_value("card1_load", 64'(1'b0), 64'(card1_load));
		check_value("card2_available", 64'(1'b1), 64'(card2_available));

		card_load_menu = 1'b1;
		next_cycle();
		check_value("card1_load", 64'(1'b1), 64'(card1_load));
		check_value("card2_load", 64'(1'b1), 64'(card2_load));
		next_cycle();
		check_value("card1_load", 64'(1'b0), 64'(card1_load));
		check_value("card2_load", 64'(1'b0), 64'(card2_load));
		card_load_menu = 1'b0;

		card_save_menu = 1'b1;
		next_cycle();
		check_value("card_save", 64'(1'b1), 64'(card_save));
		card_save_menu = 1'b0;
		// OSD opening with autosave off saves nothing
		osd_status = 1'b1;
		next_cycle();
		check_value("card_save", 64'(1'b0), 64'(card_save));
		osd_status = 1'b0;
		autosave_en = 1'b1;
		next_cycle();
		check_value("card_save", 64'(1'b0), 64'(card_save));

		// Each OSD opening with autosave on saves once
		repeat (2) begin
			osd_status = 1'b1;
			next_cycle();
			check_value("card_save", 64'(1'b1), 64'(card_save));
			next_cycle();
			check_value("card_save", 64'(1'b0), 64'(card_save));
			osd_status = 1'b0;
			next_cycle();
		end

		idle_cycles(4);
		// One executable, one SD mount, one manual and two autosaves
		check_value("exe_load pulses", 64'(1), 64'(exe_loads));
		check_value("new_cd pulses", 64'(1), 64'(new_cds));
		check_value("card_save pulses", 64'(3), 64'(card_saves));
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
